/* common/arm_pkg.sv */
package arm_pkg;

	// instruction word as data processing, load/store or branch
	typedef union packed {
		struct packed {
			logic [3:0]  cond;
			logic [1:0]  cls;     // 2'b00
			logic        imm;
			logic [3:0]  opcode;
			logic        s;
			logic [3:0]  rn;
			logic [3:0]  rd;
			logic [11:0] op2;
		} dp;
		struct packed {
			logic [3:0]  cond;
			logic [2:0]  cls;     // 3'b010 for an immediate offset
			logic        p;
			logic        u;
			logic        b;
			logic        w;
			logic        l;
			logic [3:0]  rn;
			logic [3:0]  rd;
			logic [11:0] offset;
		} ls;
		struct packed {
			logic [3:0]  cond;
			logic [2:0]  cls;     // 3'b101
			logic        link;
			logic [23:0] offset;  // signed word offset
		} br;
	} arm_instr_t;

	// data processing opcodes
	localparam logic [3:0] OP_AND = 4'b0000;
	localparam logic [3:0] OP_EOR = 4'b0001;
	localparam logic [3:0] OP_SUB = 4'b0010;
	localparam logic [3:0] OP_RSB = 4'b0011;
	localparam logic [3:0] OP_ADD = 4'b0100;
	localparam logic [3:0] OP_ADC = 4'b0101;
	localparam logic [3:0] OP_SBC = 4'b0110;
	localparam logic [3:0] OP_RSC = 4'b0111;
	localparam logic [3:0] OP_TST = 4'b1000;
	localparam logic [3:0] OP_TEQ = 4'b1001;
	localparam logic [3:0] OP_CMP = 4'b1010;
	localparam logic [3:0] OP_CMN = 4'b1011;
	localparam logic [3:0] OP_ORR = 4'b1100;
	localparam logic [3:0] OP_MOV = 4'b1101;
	localparam logic [3:0] OP_BIC = 4'b1110;
	localparam logic [3:0] OP_MVN = 4'b1111;

	// condition field
	localparam logic [3:0] COND_EQ = 4'h0;
	localparam logic [3:0] COND_NE = 4'h1;
	localparam logic [3:0] COND_CS = 4'h2;
	localparam logic [3:0] COND_CC = 4'h3;
	localparam logic [3:0] COND_MI = 4'h4;
	localparam logic [3:0] COND_PL = 4'h5;
	localparam logic [3:0] COND_VS = 4'h6;
	localparam logic [3:0] COND_VC = 4'h7;
	localparam logic [3:0] COND_HI = 4'h8;
	localparam logic [3:0] COND_LS = 4'h9;
	localparam logic [3:0] COND_GE = 4'ha;
	localparam logic [3:0] COND_LT = 4'hb;
	localparam logic [3:0] COND_GT = 4'hc;
	localparam logic [3:0] COND_LE = 4'hd;
	localparam logic [3:0] COND_AL = 4'he;

	// sequencer states
	localparam logic [1:0] ST_INIT   = 2'h0;
	localparam logic [1:0] ST_FETCH  = 2'h1;
	localparam logic [1:0] ST_DECODE = 2'h2;
	localparam logic [1:0] ST_EXEC   = 2'h3;

	localparam logic [31:0] RESET_PC = 32'h0800_0000;

	// shift types in instruction bits 6:5
	localparam logic [1:0] SH_LSL = 2'b00;
	localparam logic [1:0] SH_LSR = 2'b01;
	localparam logic [1:0] SH_ASR = 2'b10;
	localparam logic [1:0] SH_ROR = 2'b11;

	// memory access width as log2 of bytes
	localparam logic [1:0] WIDTH_BYTE = 2'h0;
	localparam logic [1:0] WIDTH_WORD = 2'h2;

endpackage

/* design/arm_control.sv */
`timescale 1ns/100ps

module arm_control (
	input  logic                clk,
	input  logic                rstn,
	input  logic [31:0]         i_mem_rdata,
	input  logic                i_mem_ok,
	input  logic [31:0]         i_pc,
	input  logic [3:0]          i_flags,
	input  logic [31:0]         i_rdata_a,
	input  logic [31:0]         i_rdata_b,
	input  logic [31:0]         i_rdata_c,
	input  logic [31:0]         i_alu_result,
	input  logic [3:0]          i_alu_flags,
	input  logic                i_alu_wr,
	output arm_pkg::arm_instr_t o_instr,
	output logic [3:0]          o_raddr_a,
	output logic [3:0]          o_raddr_b,
	output logic [3:0]          o_raddr_c,
	output logic                o_we,
	output logic [3:0]          o_waddr,
	output logic [31:0]         o_wdata,
	output logic                o_pc_we,
	output logic [31:0]         o_pc_wdata,
	output logic                o_flags_we,
	output logic [3:0]          o_flags_wdata,
	output logic [31:0]         o_mem_addr,
	output logic [31:0]         o_mem_wdata,
	output logic [1:0]          o_mem_width,
	output logic                o_mem_read,
	output logic                o_mem_write
);
	import arm_pkg::*;

	logic [1:0]  state;
	logic [1:0]  next_state;
	arm_instr_t  instr;
	logic        cond_ok;
	logic        is_dp;
	logic        is_ls;
	logic        is_br;
	logic [31:0] seq_pc;
	logic [31:0] br_target;
	logic [31:0] ls_addr;
	logic [31:0] load_data;

	function automatic logic cond_pass(input logic [3:0] cond, input logic [3:0] f);
		logic n, z, c, v;
		n = f[3];
		z = f[2];
		c = f[1];
		v = f[0];
		case (cond)
			COND_EQ: return z;
			COND_NE: return !z;
			COND_CS: return c;
			COND_CC: return !c;
			COND_MI: return n;
			COND_PL: return !n;
			COND_VS: return v;
			COND_VC: return !v;
			COND_HI: return c && !z;
			COND_LS: return !c || z;
			COND_GE: return n == v;
			COND_LT: return n != v;
			COND_GT: return !z && (n == v);
			COND_LE: return z || (n != v);
			COND_AL: return 1'b1;
			default: return 1'b0;   // NV space
		endcase
	endfunction

	// anything unclassified falls through as a no-op
	assign is_dp = instr.dp.cls == 2'b00 && (instr.dp.imm || !instr.dp.op2[4])
		&& (instr.dp.opcode[3:2] != 2'b10 || instr.dp.s);
	assign is_ls = instr.ls.cls == 3'b010 && instr.ls.p && !instr.ls.w;
	assign is_br = instr.br.cls == 3'b101;

	assign cond_ok   = cond_pass(instr.dp.cond, i_flags);
	assign seq_pc    = i_pc + 32'd4;
	// port b holds r15 (pc+8) while a branch executes
	assign br_target = i_rdata_b + {{6{instr.br.offset[23]}}, instr.br.offset, 2'b00};
	assign ls_addr   = instr.ls.u ? i_rdata_a + {20'h0, instr.ls.offset}
		: i_rdata_a - {20'h0, instr.ls.offset};
	assign load_data = instr.ls.b ? {24'h0, i_mem_rdata[7:0]} : i_mem_rdata;

	assign o_instr   = instr;
	assign o_raddr_a = instr.dp.rn;
	assign o_raddr_b = is_br ? 4'd15 : instr.dp.op2[3:0];
	assign o_raddr_c = instr.dp.rd;   // store data

	always_ff @(posedge clk) begin
		if (!rstn)
			state <= ST_INIT;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && i_mem_ok)
			instr <= i_mem_rdata;
	end

	always_comb begin
		next_state    = state;
		o_we          = 1'b0;
		o_waddr       = instr.dp.rd;
		o_wdata       = i_alu_result;
		o_pc_we       = 1'b0;
		o_pc_wdata    = seq_pc;
		o_flags_we    = 1'b0;
		o_flags_wdata = i_alu_flags;
		o_mem_addr    = i_pc;
		o_mem_wdata   = i_rdata_c;
		o_mem_width   = WIDTH_WORD;
		o_mem_read    = 1'b0;
		o_mem_write   = 1'b0;
		case (state)
			ST_INIT: begin
				o_pc_we       = 1'b1;
				o_pc_wdata    = RESET_PC;
				o_flags_we    = 1'b1;
				o_flags_wdata = 4'h0;
				next_state    = ST_FETCH;
			end
			ST_FETCH: begin
				o_mem_read = 1'b1;
				if (i_mem_ok)
					next_state = ST_DECODE;
			end
			ST_DECODE: begin
				if (cond_ok) begin
					next_state = ST_EXEC;
				end else begin
					o_pc_we    = 1'b1;   // skip
					next_state = ST_FETCH;
				end
			end
			default: begin   // ST_EXEC
				if (is_ls) begin
					o_mem_addr  = ls_addr;
					o_mem_width = instr.ls.b ? WIDTH_BYTE : WIDTH_WORD;
					o_mem_read  = instr.ls.l;
					o_mem_write = !instr.ls.l;
					if (i_mem_ok) begin
						o_we       = instr.ls.l && instr.ls.rd != 4'd15;
						o_wdata    = load_data;
						o_pc_we    = 1'b1;
						next_state = ST_FETCH;
					end
				end else if (is_br) begin
					o_pc_we    = 1'b1;
					o_pc_wdata = br_target;
					o_we       = instr.br.link;
					o_waddr    = 4'd14;
					o_wdata    = seq_pc;   // return address
					next_state = ST_FETCH;
				end else begin
					o_we       = is_dp && i_alu_wr && instr.dp.rd != 4'd15;
					o_flags_we = is_dp && instr.dp.s;
					o_pc_we    = 1'b1;
					next_state = ST_FETCH;
				end
			end
		endcase
	end

endmodule

/* design/arm_core.sv */
`timescale 1ns/100ps

module arm_core (
	input  logic        clk,
	input  logic        rstn,
	input  logic [31:0] i_mem_rdata,
	input  logic        i_mem_ok,
	output logic [31:0] o_mem_addr,
	output logic [31:0] o_mem_wdata,
	output logic [1:0]  o_mem_width,
	output logic        o_mem_read,
	output logic        o_mem_write
);
	import arm_pkg::*;

	arm_instr_t  instr;
	logic [3:0]  raddr_a;
	logic [3:0]  raddr_b;
	logic [3:0]  raddr_c;
	logic [31:0] rdata_a;
	logic [31:0] rdata_b;
	logic [31:0] rdata_c;
	logic        we;
	logic [3:0]  waddr;
	logic [31:0] wdata;
	logic        pc_we;
	logic [31:0] pc_wdata;
	logic [31:0] pc;
	logic        flags_we;
	logic [3:0]  flags_wdata;
	logic [3:0]  flags;
	logic [31:0] operand;
	logic        shift_carry;
	logic [31:0] alu_result;
	logic [3:0]  alu_flags;
	logic        alu_wr;

	arm_control u_control (
		.clk           (clk),
		.rstn          (rstn),
		.i_mem_rdata   (i_mem_rdata),
		.i_mem_ok      (i_mem_ok),
		.i_pc          (pc),
		.i_flags       (flags),
		.i_rdata_a     (rdata_a),
		.i_rdata_b     (rdata_b),
		.i_rdata_c     (rdata_c),
		.i_alu_result  (alu_result),
		.i_alu_flags   (alu_flags),
		.i_alu_wr      (alu_wr),
		.o_instr       (instr),
		.o_raddr_a     (raddr_a),
		.o_raddr_b     (raddr_b),
		.o_raddr_c     (raddr_c),
		.o_we          (we),
		.o_waddr       (waddr),
		.o_wdata       (wdata),
		.o_pc_we       (pc_we),
		.o_pc_wdata    (pc_wdata),
		.o_flags_we    (flags_we),
		.o_flags_wdata (flags_wdata),
		.o_mem_addr    (o_mem_addr),
		.o_mem_wdata   (o_mem_wdata),
		.o_mem_width   (o_mem_width),
		.o_mem_read    (o_mem_read),
		.o_mem_write   (o_mem_write)
	);

	arm_regfile u_regfile (
		.clk           (clk),
		.rstn          (rstn),
		.i_raddr_a     (raddr_a),
		.i_raddr_b     (raddr_b),
		.i_raddr_c     (raddr_c),
		.i_we          (we),
		.i_waddr       (waddr),
		.i_wdata       (wdata),
		.i_pc_we       (pc_we),
		.i_pc_wdata    (pc_wdata),
		.i_flags_we    (flags_we),
		.i_flags_wdata (flags_wdata),
		.o_rdata_a     (rdata_a),
		.o_rdata_b     (rdata_b),
		.o_rdata_c     (rdata_c),
		.o_pc          (pc),
		.o_flags       (flags)
	);

	// carry flag is bit 1 of NZCV
	arm_shifter u_shifter (
		.i_instr   (instr),
		.i_rm_data (rdata_b),
		.i_carry   (flags[1]),
		.o_operand (operand),
		.o_carry   (shift_carry)
	);

	arm_alu u_alu (
		.i_opcode      (instr.dp.opcode),
		.i_a           (rdata_a),
		.i_b           (operand),
		.i_shift_carry (shift_carry),
		.i_flags       (flags),
		.o_result      (alu_result),
		.o_flags       (alu_flags),
		.o_wr          (alu_wr)
	);

endmodule

/* design/arm_regfile.sv */
`timescale 1ns/100ps

module arm_regfile (
	input  logic        clk,
	input  logic        rstn,
	input  logic [3:0]  i_raddr_a,
	input  logic [3:0]  i_raddr_b,
	input  logic [3:0]  i_raddr_c,
	input  logic        i_we,
	input  logic [3:0]  i_waddr,
	input  logic [31:0] i_wdata,
	input  logic        i_pc_we,
	input  logic [31:0] i_pc_wdata,
	input  logic        i_flags_we,
	input  logic [3:0]  i_flags_wdata,
	output logic [31:0] o_rdata_a,
	output logic [31:0] o_rdata_b,
	output logic [31:0] o_rdata_c,
	output logic [31:0] o_pc,
	output logic [3:0]  o_flags
);

	logic [31:0] regs [0:14];   // r0..r14
	logic [31:0] pc_q;
	logic [3:0]  flags_q;       // N Z C V

	// r15 reads two instructions ahead
	function automatic logic [31:0] read_reg(input logic [3:0] addr);
		if (addr == 4'd15)
			return pc_q + 32'd8;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (i_we && i_waddr != 4'd15)
			regs[i_waddr] <= i_wdata;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc_q    <= '0;
			flags_q <= '0;
		end else begin
			if (i_pc_we)
				pc_q <= i_pc_wdata;
			if (i_flags_we)
				flags_q <= i_flags_wdata;
		end
	end

	assign o_rdata_a = read_reg(i_raddr_a);
	assign o_rdata_b = read_reg(i_raddr_b);
	assign o_rdata_c = read_reg(i_raddr_c);
	assign o_pc      = pc_q;
	assign o_flags   = flags_q;

endmodule

/* dv/tb_arm_model.svh */
logic [31:0] prog [0:PROG_LEN-1];
logic [31:0] m_regs [0:14];
logic [31:0] m_pc;
logic [3:0]  m_flags;   // N Z C V
logic [31:0] m_mem [logic [29:0]];

// untouched data memory reads back a hash of its address
function automatic logic [31:0] fill_word(input logic [29:0] waddr);
	return ({waddr, 2'b00} * 32'h9e37_79b1) ^ 32'h5bd1_e995;
endfunction

function automatic void model_reset();
	for (int i = 0; i < 15; i++)
		m_regs[i] = 32'h0;
	m_pc    = RESET_PC;
	m_flags = 4'h0;
	m_mem.delete();
endfunction

function automatic logic [31:0] model_read(input logic [3:0] r);
	return (r == 4'd15) ? m_pc + 32'd8 : m_regs[r];
endfunction

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
	return (n == 0) ? x : (x >> n) | (x << (32 - n));
endfunction

function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
	case (cond)
		COND_EQ: return f[2];
		COND_NE: return !f[2];
		COND_CS: return f[1];
		COND_CC: return !f[1];
		COND_MI: return f[3];
		COND_PL: return !f[3];
		COND_VS: return f[0];
		COND_VC: return !f[0];
		COND_HI: return f[1] && !f[2];
		COND_LS: return !(f[1] && !f[2]);
		COND_GE: return f[3] == f[0];
		COND_LT: return f[3] != f[0];
		COND_GT: return !f[2] && f[3] == f[0];
		COND_LE: return f[2] || f[3] != f[0];
		COND_AL: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

// operand 2 with the shifter carry on top
function automatic logic [32:0] operand2(input arm_instr_t ins);
	logic [31:0] rm;
	logic [31:0] val;
	logic        c;
	int          n;
	c = m_flags[1];
	if (ins.dp.imm) begin
		n   = 2 * int'(ins.dp.op2[11:8]);
		val = ror32({24'h0, ins.dp.op2[7:0]}, n);
		if (n != 0)
			c = val[31];
	end else begin
		rm = model_read(ins.dp.op2[3:0]);
		n  = int'(ins.dp.op2[11:7]);
		case (ins.dp.op2[6:5])
			SH_LSL: begin
				val = rm << n;
				if (n != 0)
					c = rm[32 - n];
			end
			SH_LSR: begin
				val = (n == 0) ? 32'h0 : rm >> n;
				c   = (n == 0) ? rm[31] : rm[n - 1];
			end
			SH_ASR: begin
				if (n == 0)
					val = {32{rm[31]}};
				else
					val = $signed(rm) >>> n;
				c   = (n == 0) ? rm[31] : rm[n - 1];
			end
			default: begin
				val = (n == 0) ? {c, rm[31:1]} : ror32(rm, n);   // rrx
				c   = (n == 0) ? rm[0] : rm[n - 1];
			end
		endcase
	end
	return {c, val};
endfunction

function automatic void alu_model(input logic [3:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic sc, output logic [31:0] res, output logic [3:0] f);
	logic [32:0] wide;
	logic [31:0] x;
	logic [31:0] y;
	logic        brw;
	logic        c;
	logic        v;
	c = sc;
	v = m_flags[0];
	case (op)
		OP_AND, OP_TST: res = a & b;
		OP_EOR, OP_TEQ: res = a ^ b;
		OP_ORR:         res = a | b;
		OP_MOV:         res = b;
		OP_BIC:         res = a & ~b;
		OP_MVN:         res = ~b;
		OP_ADD, OP_CMN, OP_ADC: begin
			wide = {1'b0, a} + {1'b0, b} + {32'h0, op == OP_ADC && m_flags[1]};
			res  = wide[31:0];
			c    = wide[32];
			v    = a[31] == b[31] && res[31] != a[31];
		end
		default: begin   // x - y - borrow
			x   = (op == OP_RSB || op == OP_RSC) ? b : a;
			y   = (op == OP_RSB || op == OP_RSC) ? a : b;
			brw = (op == OP_SBC || op == OP_RSC) ? !m_flags[1] : 1'b0;
			res = x - y - {31'h0, brw};
			c   = {1'b0, x} >= {1'b0, y} + {32'h0, brw};
			v   = x[31] != y[31] && res[31] != x[31];
		end
	endcase
	f = {res[31], res == 32'h0, c, v};
endfunction

// runs one instruction and reports the data access it expects
function automatic void model_step(input logic [31:0] word, output logic acc_valid,
		output logic acc_write, output logic [31:0] acc_addr, output logic [31:0] acc_data,
		output logic [1:0] acc_width);
	arm_instr_t  ins;
	logic [32:0] sh;
	logic [31:0] res;
	logic [31:0] addr;
	logic [31:0] w;
	logic [3:0]  f;
	logic [29:0] wa;
	ins       = word;
	acc_valid = 1'b0;
	acc_write = 1'b0;
	acc_addr  = 32'h0;
	acc_data  = 32'h0;
	acc_width = WIDTH_WORD;
	if (!cond_holds(ins.dp.cond, m_flags)) begin
		m_pc = m_pc + 32'd4;
	end else if (ins.br.cls == 3'b101) begin
		if (ins.br.link)
			m_regs[14] = m_pc + 32'd4;
		m_pc = m_pc + 32'd8 + {{6{ins.br.offset[23]}}, ins.br.offset, 2'b00};
	end else if (ins.ls.cls == 3'b010) begin
		addr = model_read(ins.ls.rn);
		addr = ins.ls.u ? addr + {20'h0, ins.ls.offset} : addr - {20'h0, ins.ls.offset};
		wa   = addr[31:2];
		w    = m_mem.exists(wa) ? m_mem[wa] : fill_word(wa);
		acc_valid = 1'b1;
		acc_write = !ins.ls.l;
		acc_addr  = addr;
		acc_width = ins.ls.b ? WIDTH_BYTE : WIDTH_WORD;
		if (ins.ls.l) begin
			m_regs[ins.ls.rd] = ins.ls.b ? (w >> (8 * addr[1:0])) & 32'hff : w;
			acc_data = m_regs[ins.ls.rd];
		end else begin
			acc_data = model_read(ins.ls.rd);
			if (ins.ls.b)
				w[8 * addr[1:0] +: 8] = acc_data[7:0];
			else
				w = acc_data;
			m_mem[wa] = w;
		end
		m_pc = m_pc + 32'd4;
	end else begin
		sh = operand2(ins);
		alu_model(ins.dp.opcode, model_read(ins.dp.rn), sh[31:0], sh[32], res, f);
		if (ins.dp.opcode[3:2] != 2'b10)
			m_regs[ins.dp.rd] = res;
		if (ins.dp.s)
			m_flags = f;
		m_pc = m_pc + 32'd4;
	end
endfunction

function automatic logic [31:0] enc_dp(input logic [3:0] cond, input logic [3:0] op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic imm,
		input logic [11:0] op2);
	return {cond, 2'b00, imm, op, s, rn, rd, op2};
endfunction

function automatic logic [31:0] enc_ls(input logic [3:0] cond, input logic u, input logic b,
		input logic l, input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] off);
	return {cond, 3'b010, 1'b1, u, b, 1'b0, l, rn, rd, off};
endfunction

function automatic logic [31:0] enc_br(input logic [3:0] cond, input logic link,
		input logic [23:0] off);
	return {cond, 3'b101, link, off};
endfunction

function automatic logic [3:0] pick_reg();
	logic [3:0] r;
	r = 4'($urandom_range(0, 13));
	return (r == 4'd13) ? 4'd14 : r;   // r13 is the data base
endfunction

function automatic logic [3:0] rand_cond();
	return ($urandom_range(0, 9) < 7) ? COND_AL : 4'($urandom_range(0, 14));
endfunction

function automatic logic [11:0] rand_off(input logic b);
	logic [11:0] o;
	o = 12'($urandom_range(0, 255));   // small window so loads hit earlier stores
	return b ? o : {o[11:2], 2'b00};
endfunction

function automatic logic [31:0] rand_dp();
	logic [3:0]  op;
	logic        s;
	logic        imm;
	logic [11:0] op2;
	op  = 4'($urandom_range(0, 15));
	s   = (op[3:2] == 2'b10) ? 1'b1 : 1'($urandom_range(0, 1));
	imm = 1'($urandom_range(0, 1));
	if (imm)
		op2 = 12'($urandom_range(0, 4095));
	else
		op2 = {5'($urandom_range(0, 31)), 2'($urandom_range(0, 3)), 1'b0,
			4'($urandom_range(0, 15))};
	return enc_dp(rand_cond(), op, s, 4'($urandom_range(0, 15)), pick_reg(), imm, op2);
endfunction

function automatic void gen_program();
	int         i;
	int         kind;
	int         lim;
	logic [3:0] rd;
	logic       b;
	prog[0] = enc_dp(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd13, 1'b1, 12'h402);   // 0x02000000
	for (i = 1; i < 15; i++)
		prog[i] = enc_dp(COND_AL, OP_MOV, 1'b0, 4'd0, (i == 14) ? 4'd14 : 4'(i - 1), 1'b1,
			12'($urandom_range(0, 4095)));
	i = 15;
	while (i < PROG_LEN) begin
		kind = int'($urandom_range(0, 9));
		b    = 1'($urandom_range(0, 1));
		if (kind == 8 && i + 3 <= PROG_LEN) begin
			// bl over one slot, then spill the link
			prog[i]     = enc_br(COND_AL, 1'b1, 24'h0);
			prog[i + 1] = rand_dp();
			prog[i + 2] = enc_ls(COND_AL, 1'($urandom_range(0, 1)), 1'b0, 1'b0, 4'd13, 4'd14,
				rand_off(1'b0));
			i += 3;
		end else if (kind == 6 && i + 2 <= PROG_LEN) begin
			rd          = pick_reg();
			prog[i]     = enc_ls(rand_cond(), 1'($urandom_range(0, 1)), b, 1'b1, 4'd13, rd,
				rand_off(b));
			prog[i + 1] = enc_ls(COND_AL, 1'($urandom_range(0, 1)), 1'b0, 1'b0, 4'd13, rd,
				rand_off(1'b0));
			i += 2;
		end else if (kind == 7 && i + 2 <= PROG_LEN) begin
			lim = PROG_LEN - i - 2;
			if (lim > 6)
				lim = 6;
			prog[i] = enc_br(rand_cond(), 1'b0, 24'($urandom_range(0, lim)));
			i++;
		end else if (kind == 5) begin
			prog[i] = enc_ls(rand_cond(), 1'($urandom_range(0, 1)), b, 1'b0, 4'd13,
				4'($urandom_range(0, 14)), rand_off(b));
			i++;
		end else begin
			prog[i] = rand_dp();
			i++;
		end
	end
endfunction

/* dv/tb_arm_core.sv */
`timescale 1ns/100ps

module tb_arm_core;
	import arm_pkg::*;

	localparam int PROG_LEN    = 200;
	localparam int NUM_TESTS   = 3;
	localparam int CYCLE_LIMIT = 40 * PROG_LEN;
	localparam logic [31:0] PROG_END = RESET_PC + 32'(4 * PROG_LEN);

	logic        clk;
	logic        rstn;
	logic [31:0] i_mem_rdata;
	logic        i_mem_ok;
	logic [31:0] o_mem_addr;
	logic [31:0] o_mem_wdata;
	logic [1:0]  o_mem_width;
	logic        o_mem_read;
	logic        o_mem_write;

	logic [31:0] dut_mem [logic [29:0]];
	logic [65:0] ref_log [$];   // width, address, data of each store
	logic [65:0] cur_log [$];
	int          errors;
	int          test_errors;
	int          cycles;
	int          n_instr;
	int          n_stores;

	`include "tb_arm_model.svh"

	arm_core u_arm_core (
		.clk         (clk),
		.rstn        (rstn),
		.i_mem_rdata (i_mem_rdata),
		.i_mem_ok    (i_mem_ok),
		.o_mem_addr  (o_mem_addr),
		.o_mem_wdata (o_mem_wdata),
		.o_mem_width (o_mem_width),
		.o_mem_read  (o_mem_read),
		.o_mem_write (o_mem_write)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: no end of program after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic report_error(input string what);
		$display("%s (cycle %0d)", what, cycles);
		test_errors++;
	endtask

	function automatic logic [31:0] mem_word(input logic [29:0] wa);
		return dut_mem.exists(wa) ? dut_mem[wa] : fill_word(wa);
	endfunction

	task automatic run_test(input int test_id, input int max_wait);
		logic        pending;
		logic        seen_first;
		logic        done;
		logic        exp_valid;
		logic        exp_write;
		logic [31:0] exp_addr;
		logic [31:0] exp_data;
		logic [1:0]  exp_width;
		logic [31:0] held_addr;
		logic [31:0] held_wdata;
		logic [1:0]  held_width;
		logic        held_write;
		logic [31:0] w;
		logic [31:0] sdata;
		logic [29:0] wa;
		int          wait_left;
		dut_mem.delete();
		cur_log.delete();
		model_reset();
		test_errors = 0;
		cycles      = 0;
		n_instr     = 0;
		n_stores    = 0;
		rstn        = 1'b0;
		i_mem_ok    = 1'b0;
		i_mem_rdata = 32'h0;
		repeat (4) begin
			@(negedge clk);
			if (o_mem_read !== 1'b0 || o_mem_write !== 1'b0)
				report_error("memory request active during reset");
		end
		rstn       = 1'b1;
		pending    = 1'b0;
		seen_first = 1'b0;
		done       = 1'b0;
		exp_valid  = 1'b0;
		wait_left  = 0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			i_mem_ok = 1'b0;
			if (pending) begin
				// request must hold until acknowledged
				if (o_mem_read !== 1'b1 && o_mem_write !== 1'b1)
					report_error("memory request dropped before acknowledge");
				check_value("o_mem_addr", o_mem_addr, held_addr);
				check_value("o_mem_width", 32'(o_mem_width), 32'(held_width));
				check_value("o_mem_write", 32'(o_mem_write), 32'(held_write));
				check_value("o_mem_read", 32'(o_mem_read), 32'(!held_write));
				if (held_write)
					check_value("o_mem_wdata", o_mem_wdata, held_wdata);
			end else if (o_mem_read === 1'b1 || o_mem_write === 1'b1) begin
				pending    = 1'b1;
				held_addr  = o_mem_addr;
				held_width = o_mem_width;
				held_write = o_mem_write;
				held_wdata = o_mem_wdata;
				wait_left  = int'($urandom_range(0, max_wait));
				if (!seen_first) begin
					seen_first = 1'b1;
					check_value("o_mem_write", 32'(o_mem_write), 32'h0);
					check_value("o_mem_addr", o_mem_addr, RESET_PC);
					check_value("o_mem_width", 32'(o_mem_width), 32'(WIDTH_WORD));
				end
			end
			if (pending && wait_left > 0) begin
				wait_left--;
			end else if (pending) begin
				pending = 1'b0;
				wa      = o_mem_addr[31:2];
				if (exp_valid) begin
					exp_valid = 1'b0;
					check_value("o_mem_write", 32'(o_mem_write), 32'(exp_write));
					check_value("o_mem_read", 32'(o_mem_read), 32'(!exp_write));
					check_value("o_mem_addr", o_mem_addr, exp_addr);
					check_value("o_mem_width", 32'(o_mem_width), 32'(exp_width));
					w = mem_word(wa);
					if (o_mem_write) begin
						sdata = (o_mem_width == WIDTH_BYTE) ? o_mem_wdata & 32'hff : o_mem_wdata;
						check_value("o_mem_wdata", sdata,
							(exp_width == WIDTH_BYTE) ? exp_data & 32'hff : exp_data);
						if (o_mem_width == WIDTH_BYTE)
							w[8 * o_mem_addr[1:0] +: 8] = o_mem_wdata[7:0];
						else
							w = o_mem_wdata;
						dut_mem[wa] = w;
						cur_log.push_back({o_mem_width, o_mem_addr, sdata});
						n_stores++;
					end else begin
						i_mem_rdata = (o_mem_width == WIDTH_BYTE) ? w >> (8 * o_mem_addr[1:0]) : w;
					end
					i_mem_ok = 1'b1;
				end else begin
					check_value("o_mem_write", 32'(o_mem_write), 32'h0);
					check_value("o_mem_read", 32'(o_mem_read), 32'h1);
					check_value("o_mem_width", 32'(o_mem_width), 32'(WIDTH_WORD));
					check_value("fetch o_mem_addr", o_mem_addr, m_pc);
					if (o_mem_addr !== m_pc || o_mem_addr == PROG_END) begin
						done = 1'b1;   // end of program or lost sync with the model
					end else begin
						i_mem_rdata = prog[(o_mem_addr - RESET_PC) >> 2];
						i_mem_ok    = 1'b1;
						model_step(i_mem_rdata, exp_valid, exp_write, exp_addr, exp_data,
							exp_width);
						n_instr++;
					end
				end
			end
		end
		if (test_id == 0) begin
			ref_log = cur_log;
		end else if (cur_log.size() != ref_log.size()) begin
			report_error("store count differs from the zero wait run");
		end else begin
			foreach (cur_log[k])
				if (cur_log[k] !== ref_log[k])
					report_error("store differs from the zero wait run");
		end
		$display("test %0d (max wait %0d): %0d instructions, %0d stores, %0d errors",
			test_id, max_wait, n_instr, n_stores, test_errors);
		errors += test_errors;
	endtask

	initial begin
		errors      = 0;
		cycles      = 0;
		rstn        = 1'b0;
		i_mem_ok    = 1'b0;
		i_mem_rdata = 32'h0;
		void'($urandom(13791));
		gen_program();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t, (t == 0) ? 0 : 3);
		$display("tests %0d, errors %0d", NUM_TESTS, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* execute/arm_alu.sv */
`timescale 1ns/100ps

module arm_alu (
	input  logic [3:0]  i_opcode,
	input  logic [31:0] i_a,
	input  logic [31:0] i_b,
	input  logic        i_shift_carry,
	input  logic [3:0]  i_flags,
	output logic [31:0] o_result,
	output logic [3:0]  o_flags,
	output logic        o_wr
);
	import arm_pkg::*;

	logic [31:0] x;
	logic [31:0] y;
	logic        cin;
	logic        arith;
	logic [32:0] sum;
	logic [31:0] logic_res;
	logic        c_out;
	logic        v_out;

	// subtracts become x + ~y + carry, so C is not-borrow
	always_comb begin
		x     = i_a;
		y     = i_b;
		cin   = 1'b0;
		arith = 1'b1;
		case (i_opcode)
			OP_SUB, OP_CMP: begin
				y   = ~i_b;
				cin = 1'b1;
			end
			OP_RSB: begin
				x   = i_b;
				y   = ~i_a;
				cin = 1'b1;
			end
			OP_ADD, OP_CMN: cin = 1'b0;
			OP_ADC: cin = i_flags[1];
			OP_SBC: begin
				y   = ~i_b;
				cin = i_flags[1];
			end
			OP_RSC: begin
				x   = i_b;
				y   = ~i_a;
				cin = i_flags[1];
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {32'h0, cin};

	always_comb begin
		case (i_opcode)
			OP_AND, OP_TST: logic_res = i_a & i_b;
			OP_EOR, OP_TEQ: logic_res = i_a ^ i_b;
			OP_ORR:         logic_res = i_a | i_b;
			OP_BIC:         logic_res = i_a & ~i_b;
			OP_MVN:         logic_res = ~i_b;
			default:        logic_res = i_b;   // MOV
		endcase
	end

	assign o_result = arith ? sum[31:0] : logic_res;

	// logical ops take C from the shifter and keep V
	assign c_out = arith ? sum[32] : i_shift_carry;
	assign v_out = arith ? (x[31] == y[31]) && (sum[31] != x[31]) : i_flags[0];

	assign o_flags = {o_result[31], o_result == 32'h0, c_out, v_out};

	// compare and test ops only set flags
	assign o_wr = i_opcode[3:2] != 2'b10;

endmodule

/* execute/arm_shifter.sv */
`timescale 1ns/100ps

module arm_shifter (
	input  arm_pkg::arm_instr_t i_instr,
	input  logic [31:0]         i_rm_data,
	input  logic                i_carry,
	output logic [31:0]         o_operand,
	output logic                o_carry
);
	import arm_pkg::*;

	logic [4:0]         rot;
	logic [63:0]        imm_pair;
	logic [4:0]         amt;
	logic [1:0]         sh_type;
	logic [32:0]        lsl_w;
	logic [32:0]        lsr_w;
	logic signed [32:0] asr_w;
	logic [63:0]        ror_w;

	// immediate is 8 bits rotated right by twice the 4-bit field
	assign rot      = {i_instr.dp.op2[11:8], 1'b0};
	assign imm_pair = {2{24'h0, i_instr.dp.op2[7:0]}} >> rot;

	assign amt     = i_instr.dp.op2[11:7];
	assign sh_type = i_instr.dp.op2[6:5];

	// one spare bit catches the last bit shifted out
	assign lsl_w = {1'b0, i_rm_data} << amt;
	assign lsr_w = {i_rm_data, 1'b0} >> amt;
	assign asr_w = $signed({i_rm_data, 1'b0}) >>> amt;
	assign ror_w = {i_rm_data, i_rm_data} >> amt;

	always_comb begin
		if (i_instr.dp.imm) begin
			o_operand = imm_pair[31:0];
			o_carry   = (rot == 5'd0) ? i_carry : imm_pair[31];
		end else begin
			case (sh_type)
				SH_LSL: begin
					o_operand = lsl_w[31:0];
					o_carry   = (amt == 5'd0) ? i_carry : lsl_w[32];
				end
				SH_LSR: begin
					o_operand = (amt == 5'd0) ? 32'h0 : lsr_w[32:1];   // #0 is #32
					o_carry   = (amt == 5'd0) ? i_rm_data[31] : lsr_w[0];
				end
				SH_ASR: begin
					o_operand = (amt == 5'd0) ? {32{i_rm_data[31]}} : asr_w[32:1];
					o_carry   = (amt == 5'd0) ? i_rm_data[31] : asr_w[0];
				end
				default: begin   // ROR where #0 means RRX
					if (amt == 5'd0) begin
						o_operand = {i_carry, i_rm_data[31:1]};
						o_carry   = i_rm_data[0];
					end else begin
						o_operand = ror_w[31:0];
						o_carry   = ror_w[31];
					end
				end
			endcase
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
verilator --binary --timing -f sources.f --top-module tb_arm_core -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { cat sim.log; exit 1; }

/* sources.f */
+incdir+dv
common/arm_pkg.sv
execute/arm_shifter.sv
execute/arm_alu.sv
design/arm_regfile.sv
design/arm_control.sv
design/arm_core.sv
dv/tb_arm_core.sv
